//--- Bender.yml
package:
  name: tinyEvg

sources:
  - files:
      - evgPkg.sv
      - heartbeatTimer.sv
      - ppsCapture.sv
      - eventArbiter.sv
      - tinyEvg.sv
  - target: test
    files:
      - tinyEvgTb.sv

//--- eventArbiter.sv
// Event arbiter building the transmit word one code per clock.
// Priority is external strobe, heartbeat, seconds marker, seconds bits, comma.
// A heartbeat that loses to a strobe is dropped while seconds traffic only waits.
// Code and K flag are registered and the distributed bus passes straight through.
// Only the low byte can carry a K character, so isK bit 1 is always 0.
`timescale 1ns/1ps

module eventArbiter (
    input  logic                   evgTxClk,
    input  logic                   rstN,
    input  logic                   eventStrobe,
    input  logic [7:0]             eventCode,
    input  logic [7:0]             distributedBus,
    input  logic                   heartbeatRequest,
    input  evgPkg::secondsCaptureT capture,
    output evgPkg::txWordT         txWord
);
    import evgPkg::*;

    localparam int unsigned bitCountWidth = $clog2(secondsWidth + 1);
    localparam int unsigned secondsGapWidth = $clog2(secondsGapCycles + 1);
    localparam int unsigned commaGapWidth = $clog2(commaGapCycles + 1);

    // A mismatch with this copy of the capture toggle means a marker is pending
    logic                        toggleCopy;
    logic [secondsWidth-1:0]     secondsShift;
    // Seconds bits still to send
    logic [bitCountWidth-1:0]    bitCount;
    logic [secondsGapWidth-1:0]  secondsGap;
    logic [commaGapWidth-1:0]    commaGap;
    logic [7:0]                  txCode;
    logic                        txIsK;

    // One-hot choice for this cycle
    logic sendStrobe;
    logic sendHeartbeat;
    logic sendMarker;
    logic sendBit;
    logic sendComma;

    always_comb begin
        sendStrobe    = 1'b0;
        sendHeartbeat = 1'b0;
        sendMarker    = 1'b0;
        sendBit       = 1'b0;
        sendComma     = 1'b0;
        if (eventStrobe) begin
            sendStrobe = 1'b1;
        end else if (heartbeatRequest) begin
            sendHeartbeat = 1'b1;
        end else if (capture.toggle != toggleCopy) begin
            sendMarker = 1'b1;
        end else if ((bitCount != '0) && (secondsGap == '0)) begin
            sendBit = 1'b1;
        end else if (commaGap == '0) begin
            sendComma = 1'b1;
        end
    end

    // The seconds gap reloads on seconds traffic and runs down in all other cycles
    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            toggleCopy <= 1'b0;
            bitCount   <= '0;
            secondsGap <= '0;
        end else if (sendMarker) begin
            toggleCopy <= capture.toggle;
            bitCount   <= bitCountWidth'(secondsWidth);
            secondsGap <= secondsGapWidth'(secondsGapCycles);
        end else if (sendBit) begin
            bitCount   <= bitCount - 1'b1;
            secondsGap <= secondsGapWidth'(secondsGapCycles);
        end else if (secondsGap != '0) begin
            secondsGap <= secondsGap - 1'b1;
        end
    end

    // MSB goes out first, so the value shifts towards the top
    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            secondsShift <= '0;
        end else if (sendMarker) begin
            secondsShift <= capture.seconds;
        end else if (sendBit) begin
            secondsShift <= {secondsShift[secondsWidth-2:0], 1'b0};
        end
    end

    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            commaGap <= '0;
        end else if (sendComma) begin
            commaGap <= commaGapWidth'(commaGapCycles);
        end else if (commaGap != '0) begin
            commaGap <= commaGap - 1'b1;
        end
    end

    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            txCode <= 8'h00;
            txIsK  <= 1'b0;
        end else begin
            txIsK <= sendComma;
            if (sendStrobe) begin
                txCode <= eventCode;
            end else if (sendHeartbeat) begin
                txCode <= evCodeHeartbeat;
            end else if (sendMarker) begin
                txCode <= evCodeSecondsMarker;
            end else if (sendBit) begin
                txCode <= secondsShift[secondsWidth-1] ? evCodeShiftOne : evCodeShiftZero;
            end else if (sendComma) begin
                txCode <= evCodeComma;
            end else begin
                // Idle slot inside the comma gap
                txCode <= 8'h00;
            end
        end
    end

    assign txWord = '{distributedBus: distributedBus, code: txCode, isK: {1'b0, txIsK}};

endmodule

//--- evgPkg.sv
// Shared constants and types of the tiny event generator.
// Timing constants assume a 125 MHz transmit clock.
// Event codes follow the usual timing-link assignments and are not configurable.
package evgPkg;

    // Event codes carried in the low byte of the transmit word
    localparam logic [7:0] evCodeShiftZero     = 8'h70;
    localparam logic [7:0] evCodeShiftOne      = 8'h71;
    localparam logic [7:0] evCodeHeartbeat     = 8'h7A;
    localparam logic [7:0] evCodeSecondsMarker = 8'h7D;
    // K28.5 comma, only meaningful with the K flag set
    localparam logic [7:0] evCodeComma         = 8'hBC;

    // Width of the seconds value sent after each marker
    localparam int unsigned secondsWidth = 32;

    // Transmit clock rate in Hz
    localparam int unsigned evgClockRate = 125000000;

    // PPS marker must stay low this long (10 us) before a new edge counts
    localparam int unsigned ppsDebounceCycles = evgClockRate / 100000;

    // Intervals at or below this value switch heartbeats off
    localparam int unsigned heartbeatMinInterval = 20;

    // Idle cycles after the seconds marker and after each seconds bit
    localparam int unsigned secondsGapCycles = 3;

    // Cycles during which a comma blocks the next comma
    localparam int unsigned commaGapCycles = 3;

    // Transmit word as it leaves the top level
    typedef struct packed {
        logic [7:0] distributedBus;
        logic [7:0] code;
        logic [1:0] isK;
    } txWordT;

    // Latest PPS capture, the toggle flips once per accepted marker
    typedef struct packed {
        logic                    toggle;
        logic [secondsWidth-1:0] seconds;
    } secondsCaptureT;

endpackage

//--- heartbeatTimer.sv
// Heartbeat request generator.
// The interval is sampled every cycle, so a change takes effect at the next expiry.
// Intervals at or below the package minimum stop requests and clear the count.
`timescale 1ns/1ps

module heartbeatTimer (
    input  logic        evgTxClk,
    input  logic        rstN,
    input  logic [31:0] heartbeatInterval,
    output logic        heartbeatRequest
);
    import evgPkg::*;

    // Remaining cycles until the next request
    logic [31:0] heartbeatCount;
    logic        intervalValid;

    // Short intervals would swamp the link, so they disable the timer
    assign intervalValid = heartbeatInterval > heartbeatMinInterval;

    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            heartbeatCount   <= '0;
            heartbeatRequest <= 1'b0;
        end else if (!intervalValid) begin
            // Hold at zero so a valid interval starts with an immediate request
            heartbeatCount   <= '0;
            heartbeatRequest <= 1'b0;
        end else if (heartbeatCount == '0) begin
            // Reload with interval minus one to get exact spacing
            heartbeatCount   <= heartbeatInterval - 32'd1;
            heartbeatRequest <= 1'b1;
        end else begin
            heartbeatCount   <= heartbeatCount - 32'd1;
            heartbeatRequest <= 1'b0;
        end
    end

endmodule

//--- ppsCapture.sv
// PPS marker capture with a two-flop synchronizer and low-time debounce.
// secondsAsync is not synchronized, so it must be stable for a few cycles
// around the marker's rising edge, or the latched value may be corrupt.
// A new edge is accepted only after the marker was low for ppsDebounceCycles.
`timescale 1ns/1ps

module ppsCapture (
    input  logic                            evgTxClk,
    input  logic                            rstN,
    input  logic                            ppsMarkerAsync,
    input  logic [evgPkg::secondsWidth-1:0] secondsAsync,
    output evgPkg::secondsCaptureT          capture
);
    import evgPkg::*;

    localparam int unsigned debounceReload = ppsDebounceCycles - 1;
    localparam int unsigned debounceWidth  = $clog2(ppsDebounceCycles);

    // Synchronizer stages where index 1 is the usable sample
    logic [1:0]                ppsSync;
    logic                      ppsMarker;
    // High from an accepted edge until the marker has been low long enough
    logic                      ppsDebounced;
    logic [debounceWidth-1:0]  debounceTimer;
    logic                      ppsToggle;
    logic [secondsWidth-1:0]   secondsLatch;
    logic                      ppsAccept;

    assign ppsMarker = ppsSync[1];

    // A high sample while the debounced state is low is a new marker
    assign ppsAccept = ppsMarker && !ppsDebounced;

    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            ppsSync <= 2'b00;
        end else begin
            ppsSync <= {ppsSync[0], ppsMarkerAsync};
        end
    end

    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            ppsDebounced  <= 1'b0;
            debounceTimer <= '0;
        end else if (ppsMarker) begin
            // Any high sample restarts the low-time measurement
            ppsDebounced  <= 1'b1;
            debounceTimer <= debounceWidth'(debounceReload);
        end else if (debounceTimer != '0) begin
            debounceTimer <= debounceTimer - 1'b1;
        end else begin
            // The marker was low long enough so the next rising edge will count
            ppsDebounced  <= 1'b0;
        end
    end

    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            ppsToggle <= 1'b0;
        end else if (ppsAccept) begin
            ppsToggle <= !ppsToggle;
        end
    end

    // Seconds are latched on the same edge that flips the toggle
    always_ff @(posedge evgTxClk or negedge rstN) begin
        if (!rstN) begin
            secondsLatch <= '0;
        end else if (ppsAccept) begin
            secondsLatch <= secondsAsync;
        end
    end

    assign capture = '{toggle: ppsToggle, seconds: secondsLatch};

endmodule

//--- tinyEvg.f
evgPkg.sv
heartbeatTimer.sv
ppsCapture.sv
eventArbiter.sv
tinyEvg.sv
tinyEvgTb.sv

//--- tinyEvg.sv
// Small event generator for a serial timing link.
// Produces one 16-bit word per evgTxClk with no back-pressure.
// ppsMarkerAsync and secondsAsync may come from any clock domain.
// Transceiver and 8b/10b coding are outside this block.
`timescale 1ns/1ps

module tinyEvg (
    input  logic                            evgTxClk,
    input  logic                            rstN,
    input  logic [31:0]                     heartbeatInterval,
    input  logic [7:0]                      distributedBus,
    input  logic [7:0]                      eventCode,
    input  logic                            eventStrobe,
    input  logic                            ppsMarkerAsync,
    input  logic [evgPkg::secondsWidth-1:0] secondsAsync,
    output logic                            ppsToggle,
    output evgPkg::txWordT                  txWord
);
    import evgPkg::*;

    logic           heartbeatRequest;
    secondsCaptureT capture;

    // Periodic heartbeat requests
    heartbeatTimer i_heartbeatTimer (
        .evgTxClk          (evgTxClk),
        .rstN              (rstN),
        .heartbeatInterval (heartbeatInterval),
        .heartbeatRequest  (heartbeatRequest)
    );

    // PPS marker and seconds value brought into the link clock domain
    ppsCapture i_ppsCapture (
        .evgTxClk       (evgTxClk),
        .rstN           (rstN),
        .ppsMarkerAsync (ppsMarkerAsync),
        .secondsAsync   (secondsAsync),
        .capture        (capture)
    );

    // Merges all sources into the transmit word
    eventArbiter i_eventArbiter (
        .evgTxClk         (evgTxClk),
        .rstN             (rstN),
        .eventStrobe      (eventStrobe),
        .eventCode        (eventCode),
        .distributedBus   (distributedBus),
        .heartbeatRequest (heartbeatRequest),
        .capture          (capture),
        .txWord           (txWord)
    );

    // Host logic watches this to know a new seconds value is expected
    assign ppsToggle = capture.toggle;

endmodule

//--- tinyEvgTb.sv
// Testbench for the tiny event generator, driven from a scenario table.
// Each row runs to completion before the next.
// The run stops at a cycle limit.
// ppsMarkerAsync is driven synchronously here, which the DUT treats as asynchronous.
`timescale 1ns/1ps

module tinyEvgTb;
    import evgPkg::*;

    typedef enum logic [2:0] {
        kindIdle, kindStrobe, kindHeartbeat, kindSeconds, kindDebounce, kindPriority
    } scenarioKindT;

    // The meaning of operand and expected depends on the kind
    // Cycles is the row length that feeds the timeout
    typedef struct packed {
        scenarioKindT kind;
        int           operand;
        int           expected;
        int           cycles;
    } scenarioT;

    localparam int rowCount = 9;
    localparam int transferWindow = 1 + secondsWidth * (secondsGapCycles + 1) + 16;

    logic                    evgTxClk;
    logic                    rstN;
    logic [31:0]             heartbeatInterval;
    logic [7:0]              distributedBus;
    logic [7:0]              eventCode;
    logic                    eventStrobe;
    logic                    ppsMarkerAsync;
    logic [secondsWidth-1:0] secondsAsync;
    logic                    ppsToggle;
    txWordT                  txWord;

    scenarioT                scenarios [rowCount];
    int unsigned             seedValue;
    int                      cycleCount = 0;
    int                      timeoutLimit = 0;
    int                      checkCount = 0;
    int                      mismatchCount = 0;
    // Monitor state is updated on the falling edge only
    int                      monitorCycle = 0;
    int                      togglesSeen = 0;
    int                      markersSeen = 0;
    int                      transfersDone = 0;
    int                      bitsReceived = 0;
    int                      heartbeatsSeen = 0;
    int                      lastHeartbeatCycle = -1;
    int                      strobeHits = 0;
    int                      heartbeatGaps [$];
    logic                    lastToggle = 1'b0;
    logic [secondsWidth-1:0] rebuild = '0;
    logic [secondsWidth-1:0] lastSeconds = '0;

    tinyEvg i_tinyEvg (
        .evgTxClk          (evgTxClk),
        .rstN              (rstN),
        .heartbeatInterval (heartbeatInterval),
        .distributedBus    (distributedBus),
        .eventCode         (eventCode),
        .eventStrobe       (eventStrobe),
        .ppsMarkerAsync    (ppsMarkerAsync),
        .secondsAsync      (secondsAsync),
        .ppsToggle         (ppsToggle),
        .txWord            (txWord)
    );

    initial begin
        evgTxClk = 1'b0;
        forever #2 evgTxClk = ~evgTxClk;
    end

    always @(posedge evgTxClk) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("Test failed");
            $finish;
        end
    end

    // The bus gets a fresh value every cycle so pass-through is always exercised
    always @(posedge evgTxClk) begin
        distributedBus <= 8'($urandom());
    end

    task automatic reportMismatch(input string msg);
        mismatchCount++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    // Decodes each word half a cycle after it changes
    always @(negedge evgTxClk) begin
        if (rstN) begin
            monitorCycle++;
            checkCount++;
            assert (txWord.isK[1] == 1'b0 && txWord.distributedBus == distributedBus) else
                reportMismatch($sformatf("word %h with bus %h", txWord, distributedBus));
            if (ppsToggle != lastToggle) begin
                togglesSeen++;
            end
            lastToggle = ppsToggle;
            if (txWord.isK == 2'b00) begin
                case (txWord.code)
                    evCodeSecondsMarker: begin
                        rebuild = '0;
                        bitsReceived = 0;
                        markersSeen++;
                    end
                    evCodeShiftZero, evCodeShiftOne: begin
                        // Bits arrive MSB first
                        rebuild = {rebuild[secondsWidth-2:0], txWord.code == evCodeShiftOne};
                        bitsReceived++;
                        if (bitsReceived == secondsWidth) begin
                            lastSeconds = rebuild;
                            transfersDone++;
                        end
                    end
                    evCodeHeartbeat: begin
                        heartbeatsSeen++;
                        if (lastHeartbeatCycle >= 0) begin
                            heartbeatGaps.push_back(monitorCycle - lastHeartbeatCycle);
                        end
                        lastHeartbeatCycle = monitorCycle;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Random user code that cannot be confused with idle or a reserved code
    function automatic logic [7:0] randomCode();
        logic [7:0] code;
        code = 8'($urandom());
        while (code == 8'h00 || code == evCodeShiftZero || code == evCodeShiftOne ||
               code == evCodeHeartbeat || code == evCodeSecondsMarker || code == evCodeComma) begin
            code = 8'($urandom());
        end
        return code;
    endfunction

    // Strobe is held for one cycle
    // The code must show in the word of the next cycle
    task automatic sendStrobe(input logic [7:0] code);
        @(posedge evgTxClk);
        eventStrobe <= 1'b1;
        eventCode   <= code;
        @(posedge evgTxClk);
        eventStrobe <= 1'b0;
        @(negedge evgTxClk);
        checkCount++;
        assert (txWord.code == code && txWord.isK == 2'b00) else
            reportMismatch($sformatf("strobe %h sent, word code %h", code, txWord.code));
        if (txWord.code == code && txWord.isK == 2'b00) begin
            strobeHits++;
        end
    endtask

    task automatic pulseMarker(input int lowCycles);
        repeat (lowCycles) @(posedge evgTxClk);
        ppsMarkerAsync <= 1'b1;
        repeat (8) @(posedge evgTxClk);
        ppsMarkerAsync <= 1'b0;
    endtask

    task automatic checkIdleCommas(input int words, input int expectedCommas);
        int commas;
        @(negedge evgTxClk);
        while (!(txWord.code == evCodeComma && txWord.isK == 2'b01)) @(negedge evgTxClk);
        commas = 1;
        for (int k = 1; k < words; k++) begin
            @(negedge evgTxClk);
            checkCount++;
            if (k % 4 == 0) begin
                assert (txWord.code == evCodeComma && txWord.isK == 2'b01) else
                    reportMismatch($sformatf("idle word %0d not a comma", k));
            end else begin
                assert (txWord.code == 8'h00 && txWord.isK == 2'b00) else
                    reportMismatch($sformatf("idle word %0d not empty", k));
            end
            if (txWord.code == evCodeComma && txWord.isK == 2'b01) begin
                commas++;
            end
        end
        checkCount++;
        assert (commas == expectedCommas) else
            reportMismatch($sformatf("%0d commas, expected %0d", commas, expectedCommas));
    endtask

    task automatic echoStrobes(input int strobes, input int expectedHits);
        int startHits;
        startHits = strobeHits;
        repeat (strobes) begin
            sendStrobe(randomCode());
            repeat (2) @(posedge evgTxClk);
        end
        checkCount++;
        assert (strobeHits - startHits == expectedHits) else
            reportMismatch($sformatf("%0d strobes echoed", strobeHits - startHits));
    endtask

    task automatic measureHeartbeats(input int interval, input int expectedCount,
                                     input int window);
        int startCount;
        @(posedge evgTxClk);
        heartbeatInterval <= interval;
        heartbeatGaps.delete();
        lastHeartbeatCycle = -1;
        startCount = heartbeatsSeen;
        repeat (window) @(posedge evgTxClk);
        heartbeatInterval <= '0;
        checkCount++;
        assert (heartbeatsSeen - startCount == expectedCount) else
            reportMismatch($sformatf("%0d heartbeats at interval %0d, expected %0d",
                heartbeatsSeen - startCount, interval, expectedCount));
        foreach (heartbeatGaps[g]) begin
            checkCount++;
            assert (heartbeatGaps[g] == interval) else
                reportMismatch($sformatf("heartbeat gap %0d", heartbeatGaps[g]));
        end
    endtask

    task automatic transferSeconds(input int withStrobes, input int expectedBits);
        logic [secondsWidth-1:0] secondsValue;
        int startTransfers;
        int startToggles;
        int startMarkers;
        secondsValue = $urandom();
        @(posedge evgTxClk);
        secondsAsync <= secondsValue;
        startTransfers = transfersDone;
        startToggles = togglesSeen;
        startMarkers = markersSeen;
        // Long low time first so the previous marker cannot block this edge
        pulseMarker(1300);
        while (transfersDone == startTransfers) begin
            if (withStrobes != 0) begin
                sendStrobe(randomCode());
                repeat (2) @(posedge evgTxClk);
            end else begin
                @(posedge evgTxClk);
            end
        end
        // Several more bit slots pass so that a surplus shift event would be seen
        repeat (4 * (secondsGapCycles + 1)) @(posedge evgTxClk);
        checkCount++;
        assert (togglesSeen - startToggles == 1 && markersSeen - startMarkers == 1 &&
                bitsReceived == expectedBits && lastSeconds == secondsValue) else
            reportMismatch($sformatf("seconds %h rebuilt as %h from %0d bits",
                secondsValue, lastSeconds, bitsReceived));
    endtask

    task automatic probeDebounce(input int lowCycles, input int expectedEdges);
        int startTransfers;
        int startToggles;
        int startMarkers;
        int waited;
        @(posedge evgTxClk);
        startTransfers = transfersDone;
        pulseMarker(1300);
        // The marker is already low while the transfer runs
        waited = 0;
        while (transfersDone == startTransfers) begin
            @(posedge evgTxClk);
            waited++;
        end
        startToggles = togglesSeen;
        startMarkers = markersSeen;
        pulseMarker(lowCycles - waited);
        repeat (transferWindow) @(posedge evgTxClk);
        checkCount++;
        assert (togglesSeen - startToggles == expectedEdges &&
                markersSeen - startMarkers == expectedEdges) else
            reportMismatch($sformatf("after %0d low cycles saw %0d toggles, %0d markers",
                lowCycles, togglesSeen - startToggles, markersSeen - startMarkers));
    endtask

    task automatic waitHeartbeat();
        @(negedge evgTxClk);
        while (!(txWord.code == evCodeHeartbeat && txWord.isK == 2'b00)) @(negedge evgTxClk);
    endtask

    task automatic dropHeartbeatOnStrobe(input int interval, input int expectedDropped);
        int longGaps;
        @(posedge evgTxClk);
        heartbeatInterval <= interval;
        heartbeatGaps.delete();
        lastHeartbeatCycle = -1;
        waitHeartbeat();
        waitHeartbeat();
        // The next request reaches the arbiter one interval after this word was built
        repeat (interval - 2) @(posedge evgTxClk);
        sendStrobe(randomCode());
        repeat (250) @(posedge evgTxClk);
        heartbeatInterval <= '0;
        longGaps = 0;
        foreach (heartbeatGaps[g]) begin
            if (heartbeatGaps[g] == 2 * interval) begin
                longGaps++;
            end else begin
                checkCount++;
                assert (heartbeatGaps[g] == interval) else
                    reportMismatch($sformatf("heartbeat gap %0d", heartbeatGaps[g]));
            end
        end
        checkCount++;
        assert (longGaps == expectedDropped) else
            reportMismatch($sformatf("%0d heartbeats dropped", longGaps));
    endtask

    initial begin
        seedValue = $urandom(32'hd083_09fd);
        rstN = 1'b0;
        heartbeatInterval = '0;
        distributedBus = 8'h00;
        eventCode = 8'h00;
        eventStrobe = 1'b0;
        ppsMarkerAsync = 1'b0;
        secondsAsync = '0;
        scenarios[0] = '{kindIdle, 40, 10, 48};
        scenarios[1] = '{kindStrobe, 8, 8, 48};
        scenarios[2] = '{kindHeartbeat, 100, 5, 450};
        scenarios[3] = '{kindHeartbeat, 20, 0, 500};
        scenarios[4] = '{kindSeconds, 0, secondsWidth, 1500};
        scenarios[5] = '{kindSeconds, 1, secondsWidth, 1600};
        scenarios[6] = '{kindDebounce, 500, 0, 2200};
        scenarios[7] = '{kindDebounce, 1300, 1, 3000};
        scenarios[8] = '{kindPriority, 100, 1, 500};
        timeoutLimit = 16;
        foreach (scenarios[r]) begin
            timeoutLimit += scenarios[r].cycles;
        end
        timeoutLimit = timeoutLimit + timeoutLimit / 4;
        repeat (16) @(posedge evgTxClk);
        rstN <= 1'b1;
        for (int r = 0; r < rowCount; r++) begin
            case (scenarios[r].kind)
                kindIdle:      checkIdleCommas(scenarios[r].operand, scenarios[r].expected);
                kindStrobe:    echoStrobes(scenarios[r].operand, scenarios[r].expected);
                kindHeartbeat: measureHeartbeats(scenarios[r].operand, scenarios[r].expected,
                                                 scenarios[r].cycles);
                kindSeconds:   transferSeconds(scenarios[r].operand, scenarios[r].expected);
                kindDebounce:  probeDebounce(scenarios[r].operand, scenarios[r].expected);
                default:       dropHeartbeatOnStrobe(scenarios[r].operand,
                                                     scenarios[r].expected);
            endcase
        end
        $display("Checks: %0d, mismatches: %0d", checkCount, mismatchCount);
        if (mismatchCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
